//--- min_pbus.f
+incdir+.
min_pbus_pkg.sv
systick.sv
sys_ctrl.sv
syscall.sv
ocspm.sv
min_pbus.sv
tb_min_pbus.sv

//--- Bender.yml
package:
  name: min_pbus

export_include_dirs:
  - .

sources:
  - min_pbus_pkg.sv
  - systick.sv
  - sys_ctrl.sv
  - syscall.sv
  - ocspm.sv
  - min_pbus.sv
  - target: test
    files:
      - tb_min_pbus.sv

//--- tb_min_pbus.sv
// Testbench for the peripheral bus top level
// Table of bus operations applied in order, reads checked in the rvalid cycle,
// plus pin checks for control bank, system call and system tick

module tb_min_pbus;

    timeunit 1ns;
    timeprecision 100ps;

    // One bus operation with its expected read byte
    typedef struct packed {
        logic                     we;
        min_pbus_pkg::pbus_addr_t adr;
        min_pbus_pkg::pbus_data_t wdat;
        min_pbus_pkg::pbus_data_t exp;
        logic                     chk;
    } op_t;

    localparam int NUM_FIXED   = 28;
    localparam int RND_N       = 64;
    localparam int NUM_OPS     = NUM_FIXED + 2 * RND_N;
    localparam int WATCHDOG_NS = (NUM_FIXED + 2 * RND_N + 200) * 8;

    logic                     clk;
    logic                     arst_n;
    min_pbus_pkg::pbus_req_t  req;
    min_pbus_pkg::pbus_rsp_t  rsp;
    logic                     syst_pause;
    logic                     mnmx;
    logic                     sync_mode;
    min_pbus_pkg::wait_cyc_t  async_waitcycle;
    logic                     systick_int;
    logic                     syscall;

    op_t                      ops [NUM_OPS];
    op_t                      exp_q [$];
    op_t                      due_op;
    logic                     read_due = 1'b0;
    min_pbus_pkg::pbus_data_t last_rdat;
    min_pbus_pkg::pbus_addr_t rnd_adr [RND_N];
    min_pbus_pkg::pbus_data_t spm_model [int];
    integer                   seed;
    int                       err_cnt = 0;
    int                       chk_cnt = 0;

    min_pbus dut_i
    (
        .clk             (clk),
        .arst_n          (arst_n),
        .req             (req),
        .rsp             (rsp),
        .syst_pause      (syst_pause),
        .mnmx            (mnmx),
        .sync_mode       (sync_mode),
        .async_waitcycle (async_waitcycle),
        .systick_int     (systick_int),
        .syscall         (syscall)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic op_t read_entry(input min_pbus_pkg::pbus_addr_t adr,
                                       input min_pbus_pkg::pbus_data_t exp);
        read_entry = {1'b0, adr, 8'h00, exp, 1'b1};
    endfunction

    function automatic op_t write_entry(input min_pbus_pkg::pbus_addr_t adr,
                                        input min_pbus_pkg::pbus_data_t dat);
        write_entry = {1'b1, adr, dat, 8'h00, 1'b0};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // One request per cycle, reads queued for the monitor
    task automatic apply_ops(input int first, input int last);
        for (int i = first; i <= last; i++)
        begin
            @(posedge clk);
            req <= {1'b1, ops[i].we, ops[i].adr, ops[i].wdat};
            if (!ops[i].we)
                exp_q.push_back(ops[i]);
        end
    endtask

    // Idle bus until the last response and side effects have settled
    task automatic drain_bus;
        @(posedge clk);
        req <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    // Strobe seen by the DUT at this edge means rvalid in the next cycle
    always @(posedge clk)
        read_due <= arst_n && req.stb && !req.we;

    // Response check in the middle of the cycle
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            check_val("rsp.rvalid", rsp.rvalid, read_due);
            if (rsp.rvalid)
                last_rdat = rsp.rdat;
            if (read_due)
            begin
                if (exp_q.size() == 0)
                begin
                    err_cnt++;
                    $display("Read response arrived with no read in flight");
                end
                else
                begin
                    due_op = exp_q.pop_front();
                    if (due_op.chk)
                        check_val("rsp.rdat", rsp.rdat, due_op.exp);
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        min_pbus_pkg::pbus_addr_t a;
        min_pbus_pkg::pbus_data_t d;
        min_pbus_pkg::pbus_data_t count_first;
        int                       k;

        req        = '0;
        syst_pause = 1'b0;
        mnmx       = 1'b1;
        arst_n     = 1'b0;
        seed       = 32'he2a8;

        // Control bank reset values and writes
        ops[0]  = read_entry(12'h6F0, 8'h81);
        ops[1]  = read_entry(12'h6F1, 8'h07);
        ops[2]  = write_entry(12'h6F0, 8'h00);
        ops[3]  = write_entry(12'h6F1, 8'h15);
        ops[4]  = read_entry(12'h6F0, 8'h80);
        ops[5]  = read_entry(12'h6F1, 8'h15);
        // Unmapped I/O bank and config gap
        ops[6]  = write_entry(12'h123, 8'h5A);
        ops[7]  = write_entry(12'h650, 8'hA5);
        ops[8]  = read_entry(12'h123, 8'h00);
        ops[9]  = read_entry(12'h650, 8'h00);
        ops[10] = read_entry(12'h6F0, 8'h80);
        ops[11] = read_entry(12'h6F1, 8'h15);
        ops[12] = read_entry(12'h601, 8'h00);
        // System call, second call while pending is dropped
        ops[13] = write_entry(12'h7A5, 8'h3C);
        ops[14] = read_entry(12'h6F2, 8'hA5);
        ops[15] = read_entry(12'h6F3, 8'h3C);
        ops[16] = write_entry(12'h711, 8'h99);
        ops[17] = read_entry(12'h6F2, 8'hA5);
        ops[18] = read_entry(12'h6F3, 8'h3C);
        ops[19] = read_entry(12'h7A5, 8'h00);
        ops[20] = write_entry(12'h6F4, 8'h01);
        // System tick, reload 10 with both enables
        ops[21] = write_entry(12'h601, 8'h0A);
        ops[22] = write_entry(12'h600, 8'h03);
        ops[23] = read_entry(12'h603, 8'h01);
        ops[24] = read_entry(12'h601, 8'h0A);
        ops[25] = write_entry(12'h603, 8'h01);
        ops[26] = read_entry(12'h603, 8'h00);
        ops[27] = read_entry(12'h602, 8'h00);
        ops[27].chk = 1'b0;

        // Random scratchpad writes, then read back newest first
        for (k = 0; k < RND_N; k++)
        begin
            a = {1'b1, 11'($random(seed))};
            d = 8'($random(seed));
            spm_model[int'(a)] = d;
            rnd_adr[k] = a;
            ops[NUM_FIXED + k] = write_entry(a, d);
        end
        for (k = 0; k < RND_N; k++)
        begin
            a = rnd_adr[RND_N - 1 - k];
            ops[NUM_FIXED + RND_N + k] = read_entry(a, spm_model[int'(a)]);
        end

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        apply_ops(0, 1);
        drain_bus();
        check_val("sync_mode", sync_mode, 1);
        check_val("async_waitcycle", async_waitcycle, 7);
        apply_ops(2, 5);
        drain_bus();
        check_val("sync_mode", sync_mode, 0);
        check_val("async_waitcycle", async_waitcycle, 8'h15);
        apply_ops(6, 12);
        drain_bus();

        apply_ops(13, 15);
        drain_bus();
        check_val("syscall", syscall, 1);
        apply_ops(16, 19);
        drain_bus();
        check_val("syscall", syscall, 1);
        apply_ops(20, 20);
        drain_bus();
        check_val("syscall", syscall, 0);

        apply_ops(21, 22);
        drain_bus();
        // Longer than one full reload period of 11 cycles
        repeat (13) @(posedge clk);
        apply_ops(23, 24);
        drain_bus();
        check_val("systick_int", systick_int, 1);
        // Freeze the counter so no new tick races the clear
        @(posedge clk);
        syst_pause <= 1'b1;
        apply_ops(25, 26);
        drain_bus();
        check_val("systick_int", systick_int, 0);
        apply_ops(27, 27);
        drain_bus();
        count_first = last_rdat;
        repeat (5) @(posedge clk);
        apply_ops(27, 27);
        drain_bus();
        check_val("COUNT", last_rdat, count_first);
        @(posedge clk);
        syst_pause <= 1'b0;

        apply_ops(NUM_FIXED, NUM_OPS - 1);
        drain_bus();

        if (exp_q.size() != 0)
        begin
            err_cnt++;
            $display("%0d reads never got a response", exp_q.size());
        end

        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- min_pbus.sv
// Peripheral bus top level
// Decodes the 4 KB window onto timer, control bank, system call
// area and scratchpad; reads return one cycle after the strobe

`include "min_pbus_cfg.svh"

module min_pbus
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  min_pbus_pkg::pbus_req_t req,
    output min_pbus_pkg::pbus_rsp_t rsp,
    input  logic                    syst_pause,
    input  logic                    mnmx,
    output logic                    sync_mode,
    output min_pbus_pkg::wait_cyc_t async_waitcycle,
    output logic                    systick_int,
    output logic                    syscall
);

    // One select per block
    typedef struct packed {
        logic stk;
        logic syc;
        logic scl;
        logic spm;
    } blk_sel_t;

    blk_sel_t                 sel;
    blk_sel_t                 rd_sel;
    logic                     rd_pend;
    min_pbus_pkg::pbus_req_t  req_stk;
    min_pbus_pkg::pbus_req_t  req_syc;
    min_pbus_pkg::pbus_req_t  req_scl;
    min_pbus_pkg::pbus_req_t  req_spm;
    min_pbus_pkg::pbus_data_t rdat_stk;
    min_pbus_pkg::pbus_data_t rdat_syc;
    min_pbus_pkg::pbus_data_t rdat_spm;
    min_pbus_pkg::pbus_data_t syscall_num;
    min_pbus_pkg::pbus_data_t syscall_info;
    logic                     syscall_clr;

    // Address decode; I/O bank and 0x610..0x6EF match nothing
    assign sel.stk = req.stb && req.adr[`PBUS_ADDR_W-1 -: $bits(`STK_BASE)] == `STK_BASE;
    assign sel.syc = req.stb && req.adr[`PBUS_ADDR_W-1 -: $bits(`SYC_BASE)] == `SYC_BASE;
    assign sel.scl = req.stb && req.adr[`PBUS_ADDR_W-1 -: $bits(`SCL_BASE)] == `SCL_BASE;
    assign sel.spm = req.stb && req.adr[`PBUS_ADDR_W-1 -: $bits(`SPM_BASE)] == `SPM_BASE;

    // Same request to each block, own strobe
    always_comb
    begin
        req_stk     = req;
        req_stk.stb = sel.stk;
        req_syc     = req;
        req_syc.stb = sel.syc;
        req_scl     = req;
        req_scl.stb = sel.scl;
        req_spm     = req;
        req_spm.stb = sel.spm;
    end

    // Remember which block answers the read in flight
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_pend <= 1'b0;
            rd_sel  <= '0;
        end
        else
        begin
            rd_pend <= req.stb & ~req.we;
            rd_sel  <= (req.stb && !req.we) ? sel : '0;
        end
    end

    assign rsp.rvalid = rd_pend;

    // Read mux, unmapped and system call reads give zero
    always_comb
    begin
        case (rd_sel)
            blk_sel_t'(4'b1000): rsp.rdat = rdat_stk;
            blk_sel_t'(4'b0100): rsp.rdat = rdat_syc;
            blk_sel_t'(4'b0001): rsp.rdat = rdat_spm;
            default:             rsp.rdat = '0;
        endcase
    end

    systick systick_i
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req_stk),
        .syst_pause  (syst_pause),
        .rdat        (rdat_stk),
        .systick_int (systick_int)
    );

    sys_ctrl sys_ctrl_i
    (
        .clk             (clk),
        .arst_n          (arst_n),
        .req             (req_syc),
        .mnmx            (mnmx),
        .syscall_num     (syscall_num),
        .syscall_info    (syscall_info),
        .rdat            (rdat_syc),
        .sync_mode       (sync_mode),
        .async_waitcycle (async_waitcycle),
        .syscall_clr     (syscall_clr)
    );

    syscall syscall_i
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req_scl),
        .syscall_clr  (syscall_clr),
        .syscall      (syscall),
        .syscall_num  (syscall_num),
        .syscall_info (syscall_info)
    );

    ocspm ocspm_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req_spm),
        .rdat   (rdat_spm)
    );

    // Block windows never overlap
    a_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(sel));

endmodule

//--- ocspm.sv
// On-chip scratchpad memory
// Single-port byte array, write at the strobe edge,
// read data registered on a strobed read

`include "min_pbus_cfg.svh"

module ocspm
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  min_pbus_pkg::pbus_req_t  req,
    output min_pbus_pkg::pbus_data_t rdat
);

    localparam int SPM_AW    = $clog2(`SPM_DEPTH);
    localparam int SPM_START = int'(`SPM_BASE) << SPM_AW;

    min_pbus_pkg::pbus_data_t mem [`SPM_DEPTH];
    logic [SPM_AW-1:0]        addr;

    assign addr = req.adr[SPM_AW-1:0];

    // Byte write
    always_ff @(posedge clk)
    begin
        if (req.stb && req.we)
            mem[addr] <= req.wdat;
    end

    // Registered read
    always_ff @(posedge clk)
    begin
        if (req.stb && !req.we)
            rdat <= mem[addr];
    end

    // Top decode keeps every strobe inside the array
    a_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
        req.stb |-> (int'(req.adr) >= SPM_START)
                 && (int'(req.adr) - SPM_START < `SPM_DEPTH));

endmodule

//--- syscall.sv
// System call area
// 256-byte write-only window; a write latches the call number
// from the low address byte and the argument from the data

module syscall
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  min_pbus_pkg::pbus_req_t  req,
    input  logic                     syscall_clr,
    output logic                     syscall,
    output min_pbus_pkg::pbus_data_t syscall_num,
    output min_pbus_pkg::pbus_data_t syscall_info
);

    logic call_wr;

    // Only a write with no call pending is taken
    assign call_wr = req.stb & req.we & ~syscall;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            syscall      <= 1'b0;
            syscall_num  <= '0;
            syscall_info <= '0;
        end
        else if (call_wr)
        begin
            syscall      <= 1'b1;
            syscall_num  <= req.adr[7:0];
            syscall_info <= req.wdat;
        end
        else if (syscall_clr)
        begin
            // Number and argument stay for readback
            syscall <= 1'b0;
        end
    end

    // Clear from the control bank only arrives for a pending call
    a_clr_pending: assert property (@(posedge clk) disable iff (!arst_n)
        syscall_clr |-> syscall);

endmodule

//--- sys_ctrl.sv
// System control register bank
// Bus mode and wait cycles for the external bridge,
// readback of the pending system call and its clear strobe

`include "min_pbus_cfg.svh"

module sys_ctrl
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  min_pbus_pkg::pbus_req_t  req,
    input  logic                     mnmx,
    input  min_pbus_pkg::pbus_data_t syscall_num,
    input  min_pbus_pkg::pbus_data_t syscall_info,
    output min_pbus_pkg::pbus_data_t rdat,
    output logic                     sync_mode,
    output min_pbus_pkg::wait_cyc_t  async_waitcycle,
    output logic                     syscall_clr
);

    // Register slots on adr[3:0]
    localparam logic [3:0] SLOT_MODE = 4'h0;
    localparam logic [3:0] SLOT_WAIT = 4'h1;
    localparam logic [3:0] SLOT_NUM  = 4'h2;
    localparam logic [3:0] SLOT_INFO = 4'h3;
    localparam logic [3:0] SLOT_CLR  = 4'h4;

    logic [3:0] slot;
    logic       wr;
    logic       rd;

    assign slot = req.adr[3:0];
    assign wr   = req.stb & req.we;
    assign rd   = req.stb & ~req.we;

    // Mode and wait cycle registers
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_mode       <= `SYNC_MODE_RST;
            async_waitcycle <= `WAIT_CYC_RST;
        end
        else if (wr && slot == SLOT_MODE)
            sync_mode <= req.wdat[0];
        else if (wr && slot == SLOT_WAIT)
            async_waitcycle <= req.wdat[`WAIT_CYC_W-1:0];
    end

    // Any write to slot 4 gives a one-cycle clear
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            syscall_clr <= 1'b0;
        else
            syscall_clr <= wr && (slot == SLOT_CLR);
    end

    // Read data, empty slots return zero
    always_ff @(posedge clk)
    begin
        if (rd)
        begin
            case (slot)
                SLOT_MODE: rdat <= {mnmx, 6'b0, sync_mode};
                SLOT_WAIT: rdat <= min_pbus_pkg::pbus_data_t'(async_waitcycle);
                SLOT_NUM:  rdat <= syscall_num;
                SLOT_INFO: rdat <= syscall_info;
                default:   rdat <= '0;
            endcase
        end
    end

endmodule

//--- systick.sv
// System tick timer
// Down counter reloaded from RELOAD on zero, with pause input,
// sticky status flag and a masked interrupt output

module systick
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  min_pbus_pkg::pbus_req_t req,
    input  logic                    syst_pause,
    output min_pbus_pkg::pbus_data_t rdat,
    output logic                    systick_int
);

    min_pbus_pkg::stk_reg_e  reg_sel;
    min_pbus_pkg::pbus_data_t reload;
    min_pbus_pkg::pbus_data_t count;
    logic                    ctrl_en;
    logic                    ctrl_ie;
    logic                    flag;
    logic                    wr;
    logic                    rd;
    logic                    run;
    logic                    tick_zero;

    assign reg_sel = min_pbus_pkg::stk_reg_e'(req.adr[1:0]);
    assign wr      = req.stb & req.we;
    assign rd      = req.stb & ~req.we;

    // Counting only while enabled and not held by the debugger
    assign run       = ctrl_en & ~syst_pause;
    assign tick_zero = run & (count == '0);

    // CTRL and RELOAD registers
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ctrl_en <= 1'b0;
            ctrl_ie <= 1'b0;
            reload  <= '0;
        end
        else if (wr && reg_sel == min_pbus_pkg::CTRL)
        begin
            ctrl_en <= req.wdat[0];
            ctrl_ie <= req.wdat[1];
        end
        else if (wr && reg_sel == min_pbus_pkg::RELOAD)
        begin
            reload <= req.wdat;
        end
    end

    // Down counter with COUNT read-only
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (tick_zero)
            count <= reload;
        else if (run)
            count <= count - 1'b1;
    end

    // Sticky status flag cleared by writing 1
    // A reload in the same cycle wins over the clear
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            flag <= 1'b0;
        else if (tick_zero)
            flag <= 1'b1;
        else if (wr && reg_sel == min_pbus_pkg::STATUS && req.wdat[0])
            flag <= 1'b0;
    end

    assign systick_int = flag & ctrl_ie;

    // Read data register
    always_ff @(posedge clk)
    begin
        if (rd)
        begin
            case (reg_sel)
                min_pbus_pkg::CTRL:   rdat <= {6'b0, ctrl_ie, ctrl_en};
                min_pbus_pkg::RELOAD: rdat <= reload;
                min_pbus_pkg::COUNT:  rdat <= count;
                min_pbus_pkg::STATUS: rdat <= {7'b0, flag};
                default:              rdat <= '0;
            endcase
        end
    end

    // Count rises only on a reload and never past RELOAD
    a_reload_bound: assert property (@(posedge clk) disable iff (!arst_n)
        (count > $past(count)) |-> ($past(tick_zero) && (count <= $past(reload))));

endmodule

//--- min_pbus_pkg.sv
// Peripheral bus types
// Address and data types, request and response structs,
// and the system tick timer register names

`include "min_pbus_cfg.svh"

package min_pbus_pkg;

    // Byte address inside the 4 KB window
    typedef logic [`PBUS_ADDR_W-1:0] pbus_addr_t;

    // One data byte
    typedef logic [`PBUS_DATA_W-1:0] pbus_data_t;

    // Wait cycles inserted on the asynchronous external bus
    typedef logic [`WAIT_CYC_W-1:0] wait_cyc_t;

    // CPU request, one strobed transfer per cycle
    typedef struct packed {
        logic       stb;
        logic       we;
        pbus_addr_t adr;
        pbus_data_t wdat;
    } pbus_req_t;

    // Read response, valid one cycle after the strobe
    typedef struct packed {
        logic       rvalid;
        pbus_data_t rdat;
    } pbus_rsp_t;

    // Timer registers, decoded on adr[1:0]
    typedef enum logic [1:0] {
        CTRL   = 2'd0,
        RELOAD = 2'd1,
        COUNT  = 2'd2,
        STATUS = 2'd3
    } stk_reg_e;

endpackage

//--- min_pbus_cfg.svh
// Peripheral bus configuration
// Address map, bus widths and reset values for the 4 KB window

`ifndef MIN_PBUS_CFG_SVH
`define MIN_PBUS_CFG_SVH

// Bus widths
`define PBUS_ADDR_W 12
`define PBUS_DATA_W 8

// Asynchronous bus wait cycle counter width
`define WAIT_CYC_W 7

// Scratchpad size in bytes
`define SPM_DEPTH 2048

// Upper address match values
// Timer at 0x600..0x60F, compared on adr[11:4]
`define STK_BASE 8'h60
// Control bank at 0x6F0..0x6FF, compared on adr[11:4]
`define SYC_BASE 8'h6F
// System call area at 0x700..0x7FF, compared on adr[11:8]
`define SCL_BASE 4'h7
// Scratchpad at 0x800..0xFFF, compared on adr[11]
`define SPM_BASE 1'b1

// Control bank reset values
`define SYNC_MODE_RST 1'b1
`define WAIT_CYC_RST 7'd7

`endif
